/* mips_core.f */
+incdir+include
rtl/mips_isa_pkg.sv
rtl/mips_ctrl_pkg.sv
rtl/decode_if.sv
rtl/cpu_sequencer.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/exec_unit.sv
rtl/pc_unit.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mips_core.f --top-module tb_mips_core -o sim_mips_core

./obj_dir/sim_mips_core > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
grep -q "Regression passed" sim.log

/* tb/tb_mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module tb_mips_core;
  import mips_isa_pkg::*;

  localparam int BODY       = 24;        // random part, terminator starts here
  localparam int PROG_WORDS = BODY + 3;
  localparam int N_TESTS    = 6;
  localparam logic [31:0] DATA_BASE = 32'h0000_1000;
  // fetch and data access take up to 4 cycles each per instruction on top of reset
  localparam int WATCHDOG_CYCLES = N_TESTS * (PROG_WORDS * 4 * 4 + 40) + 200;

  logic        clk, reset, waitrequest, active, write, read;
  logic [31:0] readdata, register_v0, address, writedata;

  logic [31:0] lfsr = 32'h9d2f_1bd2;
  logic [31:0] dut_mem [logic [31:0]];    // word address keys
  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] mregs [32];                // reference register file
  logic [31:0] dut_reads [$];             // every completed read address
  logic [31:0] model_reads [$];
  logic [31:0] prog [PROG_WORDS];
  int          errors, tests_failed, wait_left, model_steps;
  logic        rst_s, halted_bus;

  mips_core dut (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .address(address), .write(write), .read(read), .waitrequest(waitrequest),
    .writedata(writedata), .readdata(readdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < nbits; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // unwritten words read back a value mixed from the full address
  function automatic logic [31:0] fill_word(input logic [31:0] waddr);
    return (waddr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] dut_word(input logic [31:0] a);
    return dut_mem.exists(a >> 2) ? dut_mem[a >> 2] : fill_word(a >> 2);
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    return model_mem.exists(a >> 2) ? model_mem[a >> 2] : fill_word(a >> 2);
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] enc_r(input funct_t fn, input logic [4:0] rs, rt, rd);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(input opcode_t op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [4:0] rreg();
    return 5'(rnd(4));  // r0..r15 so r20 keeps the data base
  endfunction

  function automatic logic [31:0] gen_alu();
    logic [15:0] imm;
    imm = 16'(rnd(16));
    case (rnd(4) % 12)
      0:  return enc_r(FN_ADDU, rreg(), rreg(), rreg());
      1:  return enc_r(FN_SUBU, rreg(), rreg(), rreg());
      2:  return enc_r(FN_AND, rreg(), rreg(), rreg());
      3:  return enc_r(FN_OR, rreg(), rreg(), rreg());
      4:  return enc_r(FN_XOR, rreg(), rreg(), rreg());
      5:  return enc_r(FN_SLT, rreg(), rreg(), rreg());
      6:  return enc_i(OP_ADDIU, rreg(), rreg(), imm);
      7:  return enc_i(OP_SLTI, rreg(), rreg(), imm);
      8:  return enc_i(OP_ANDI, rreg(), rreg(), imm);
      9:  return enc_i(OP_ORI, rreg(), rreg(), imm);
      10: return enc_i(OP_XORI, rreg(), rreg(), imm);
      default: return enc_i(OP_LUI, 5'd0, rreg(), imm);
    endcase
  endfunction

  // kind 0 is alu only while 1 adds lw/sw and 2 adds forward branches and jumps
  task automatic gen_program(input int kind);
    logic [31:0] sel, ta;
    int          tgt;
    logic        prev_ctrl;
    prog[0]   = enc_i(OP_ORI, 5'd0, 5'd20, DATA_BASE[15:0]);
    prev_ctrl = 1'b0;
    for (int p = 1; p < BODY; p++) begin
      sel = rnd(4);
      if (!prev_ctrl && kind == 2 && sel < 6 && p + 1 < BODY) begin
        tgt = p + 2 + int'(rnd(2) % 3);  // always past the delay slot
        if (tgt > BODY) tgt = BODY;
        ta = `MIPS_RESET_PC + 32'(tgt * 4);
        if (sel < 2) prog[p] = {OP_J, ta[27:2]};
        else prog[p] = enc_i((sel < 4) ? OP_BEQ : OP_BNE, rreg(), rreg(), 16'(tgt - p - 1));
        prev_ctrl = 1'b1;  // no branch in a delay slot
      end else begin
        if (kind == 1 && sel < 8)  // unaligned offsets exercise the forced word alignment
          prog[p] = enc_i(sel[0] ? OP_LW : OP_SW, 5'd20, rreg(), 16'(rnd(6)));
        else
          prog[p] = gen_alu();
        prev_ctrl = 1'b0;
      end
    end
    prog[BODY]     = enc_i(OP_ORI, 5'd0, 5'd8, 16'h0);  // r8 = 0
    prog[BODY + 1] = enc_r(FN_JR, 5'd8, 5'd0, 5'd0);    // jump to halt address
    prog[BODY + 2] = 32'h0;                             // nop in the slot
  endtask

  // isa reference model where the pc/npc pair gives the delay slot
  task automatic run_model();
    logic [31:0] pc, npc, nn, ins, rs, rt, simm, zimm, res, maddr;
    logic [5:0]  op, fn;
    logic        wr;
    foreach (mregs[i]) mregs[i] = '0;
    model_reads.delete();
    pc          = `MIPS_RESET_PC;
    npc         = pc + 32'd4;
    model_steps = 0;
    while (pc != `MIPS_HALT_PC && model_steps < 1000) begin
      model_reads.push_back(pc);
      ins   = model_word(pc);
      op    = ins[31:26];
      fn    = ins[5:0];
      nn    = npc + 32'd4;
      rs    = mregs[ins[25:21]];
      rt    = mregs[ins[20:16]];
      simm  = {{16{ins[15]}}, ins[15:0]};
      zimm  = {16'h0, ins[15:0]};
      maddr = (rs + simm) & 32'hFFFF_FFFC;
      res   = '0;
      wr    = (op == 6'h00) ? (fn inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2A})
                            : (op inside {6'h09, 6'h0A, 6'h0C, 6'h0D, 6'h0E, 6'h0F, 6'h23});
      case (op)
        6'h00: begin
          case (fn)
            6'h21: res = rs + rt;
            6'h23: res = rs - rt;
            6'h24: res = rs & rt;
            6'h25: res = rs | rt;
            6'h26: res = rs ^ rt;
            6'h2A: res = {31'd0, $signed(rs) < $signed(rt)};
            6'h08: nn = rs;  // jr
            default: ;
          endcase
        end
        6'h09: res = rs + simm;
        6'h0A: res = {31'd0, $signed(rs) < $signed(simm)};
        6'h0C: res = rs & zimm;
        6'h0D: res = rs | zimm;
        6'h0E: res = rs ^ zimm;
        6'h0F: res = {ins[15:0], 16'h0};
        6'h04: if (rs == rt) nn = npc + (simm << 2);
        6'h05: if (rs != rt) nn = npc + (simm << 2);
        6'h02: nn = {npc[31:28], ins[25:0], 2'b00};
        6'h23: begin
          model_reads.push_back(maddr);
          res = model_word(maddr);
        end
        6'h2B: model_mem[maddr >> 2] = rt;
        default: ;
      endcase
      if (wr && ((op == 6'h00) ? ins[15:11] : ins[20:16]) != 5'd0)
        mregs[(op == 6'h00) ? ins[15:11] : ins[20:16]] = res;
      pc  = npc;
      npc = nn;
      model_steps++;
    end
  endtask

  // avalon slave with 0..3 wait cycles per request driven 2 ns after the edge
  initial begin
    wait_left = -1;
    forever begin
      @(negedge clk);
      rst_s = reset;
      if (!reset) begin
        if (read && write) begin
          $display("Error at %0t ns: read and write are high together", $time);
          errors++;
        end
        if (!active && (read || write)) halted_bus = 1'b1;
        if ((read || write) && !waitrequest) begin  // transfer ends at the next edge
          if (address[1:0] != 2'b00) begin
            $display("Error at %0t ns: bus address %h is not word aligned", $time, address);
            errors++;
          end
          if (read) dut_reads.push_back(address);
          else dut_mem[address >> 2] = writedata;
          wait_left = -1;
        end
      end
      @(posedge clk);
      #2;
      if ((rst_s !== 1'b0) || !(read || write)) begin
        waitrequest = 1'b1;
        wait_left   = -1;
      end else begin
        if (wait_left < 0) wait_left = int'(rnd(2));  // new request
        if (wait_left > 0) begin
          waitrequest = 1'b1;
          wait_left--;
        end else begin
          waitrequest = 1'b0;
          readdata    = dut_word(address);
        end
      end
    end
  end

  task automatic run_test(input int t, input int kind);
    int err0;
    err0 = errors;
    gen_program(kind);
    dut_mem.delete();
    model_mem.delete();
    dut_reads.delete();
    for (int p = 0; p < PROG_WORDS; p++) begin
      dut_mem[(`MIPS_RESET_PC >> 2) + 32'(p)]   = prog[p];
      model_mem[(`MIPS_RESET_PC >> 2) + 32'(p)] = prog[p];
    end
    run_model();
    halted_bus = 1'b0;
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    check_eq({31'b0, active}, 32'd1, "active after reset");
    check_eq({31'b0, write}, 32'd0, "write after reset");
    check_eq({31'b0, read}, 32'd1, "read in first fetch");
    check_eq(address, `MIPS_RESET_PC, "first fetch address");
    while (active === 1'b1) @(negedge clk);  // runs until the core halts
    repeat (8) @(posedge clk);               // bus must stay quiet once halted
    @(negedge clk);
    check_eq({31'b0, active}, 32'd0, "active after halt");
    if (halted_bus) begin
      $display("Error at %0t ns: bus request seen after the core halted", $time);
      errors++;
    end
    check_eq(register_v0, mregs[2], "register_v0");
    for (int w = 0; w < 16; w++)
      check_eq(dut_word(DATA_BASE + 32'(w * 4)), model_word(DATA_BASE + 32'(w * 4)),
               "data memory word");
    check_eq(32'(dut_reads.size()), 32'(model_reads.size()), "number of bus reads");
    for (int i = 0; i < dut_reads.size() && i < model_reads.size(); i++)
      check_eq(dut_reads[i], model_reads[i], "bus read address");
    if (errors != err0) tests_failed++;
    $display("test %0d kind %0d: %0d instructions, %s", t, kind, model_steps,
             (errors == err0) ? "ok" : "FAILED");
  endtask

  initial begin
    reset        = 1'b1;
    waitrequest  = 1'b1;
    readdata     = '0;
    errors       = 0;
    tests_failed = 0;
    halted_bus   = 1'b0;
    for (int t = 0; t < N_TESTS; t++) run_test(t, t % 3);
    $display("%0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog sized from the worst case of all programs
  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Timeout: the core did not halt within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module mips_core (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  active,
  output logic [`MIPS_XLEN-1:0] register_v0,
  // avalon-mm master
  output logic [`MIPS_XLEN-1:0] address,
  output logic                  write,
  output logic                  read,
  input  logic                  waitrequest,
  output logic [`MIPS_XLEN-1:0] writedata,
  input  logic [`MIPS_XLEN-1:0] readdata
);

  mips_ctrl_pkg::cpu_state_t state;

  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] mem_addr;     // word aligned data address
  logic                  halt_next;
  logic [4:0]            rs_addr, rt_addr, wr_addr;
  logic [`MIPS_XLEN-1:0] rs_data, rt_data, wr_data;
  logic                  reg_we;
  logic                  take_branch;

  decode_if dec_bus ();

  cpu_sequencer u_seq (
    .clk(clk), .reset(reset), .waitrequest(waitrequest),
    .mem_read(dec_bus.ctrl.mem_read), .mem_write(dec_bus.ctrl.mem_write),
    .pc(pc), .mem_addr(mem_addr),
    .state(state), .active(active), .read(read), .write(write),
    .address(address), .halt_next(halt_next)
  );

  instr_decoder u_dec (
    .clk(clk), .reset(reset), .state(state),
    .readdata(readdata), .waitrequest(waitrequest),
    .rs_addr(rs_addr), .rt_addr(rt_addr),
    .dec(dec_bus.decode),
    .rs_data(rs_data), .rt_data(rt_data)
  );

  register_file u_rf (
    .clk(clk), .reset(reset), .we(reg_we),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
  );

  exec_unit u_exec (
    .clk(clk), .reset(reset), .state(state), .waitrequest(waitrequest),
    .readdata(readdata), .ex(dec_bus.exec),
    .mem_addr(mem_addr), .writedata(writedata),
    .wr_addr(wr_addr), .wr_data(wr_data), .reg_we(reg_we),
    .take_branch(take_branch)
  );

  pc_unit u_pc (
    .clk(clk), .reset(reset), .state(state), .ex(dec_bus.exec),
    .take_branch(take_branch), .pc(pc), .halt_next(halt_next)
  );

endmodule

`default_nettype wire

/* rtl/pc_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module pc_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  mips_ctrl_pkg::cpu_state_t state,
  decode_if.exec                    ex,
  input  logic                      take_branch,
  output logic [`MIPS_XLEN-1:0]     pc,
  output logic                      halt_next
);
  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] pc_plus4, branch_addr, jump_addr, tgt_addr;
  logic [`MIPS_XLEN-1:0] tgt_q;    // target waiting behind the delay slot
  logic                  delay_q;  // current instruction is a delay slot
  logic                  redirect;
  logic [`MIPS_XLEN-1:0] next_pc;

  assign pc_plus4    = pc + 32'd4;
  assign branch_addr = pc_plus4 + {ex.imm[`MIPS_XLEN-3:0], 2'b00};  // offset from delay slot
  assign jump_addr   = {pc_plus4[31:28], ex.jtarget, 2'b00};

  assign tgt_addr = ex.ctrl.jumpreg ? ex.rs_data :
                    ex.ctrl.jump    ? jump_addr   : branch_addr;
  assign redirect = take_branch | ex.ctrl.jump | ex.ctrl.jumpreg;

  // delay slot runs from pc+4, the held target comes after it
  assign next_pc   = delay_q ? tgt_q : pc_plus4;
  assign halt_next = (next_pc == `MIPS_HALT_PC);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= `MIPS_RESET_PC;
      delay_q <= 1'b0;
    end else if (state == EXEC) begin
      pc      <= next_pc;
      delay_q <= redirect;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == EXEC) && redirect) tgt_q <= tgt_addr;
  end

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module exec_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  mips_ctrl_pkg::cpu_state_t state,
  input  logic                      waitrequest,
  input  logic [`MIPS_XLEN-1:0]     readdata,
  decode_if.exec                    ex,
  output logic [`MIPS_XLEN-1:0]     mem_addr,
  output logic [`MIPS_XLEN-1:0]     writedata,
  output logic [4:0]                wr_addr,
  output logic [`MIPS_XLEN-1:0]     wr_data,
  output logic                      reg_we,
  output logic                      take_branch
);
  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] op_a, op_b;
  logic [`MIPS_XLEN-1:0] alu_res;
  logic [`MIPS_XLEN-1:0] load_q;  // lw data held from MEM to EXEC

  assign op_a = ex.rs_data;
  assign op_b = ex.ctrl.alu_src_imm ? ex.imm : ex.rt_data;

  always_comb begin
    case (ex.ctrl.alu_op)
      ALU_ADD: alu_res = op_a + op_b;
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_LUI: alu_res = {op_b[15:0], 16'b0};
      default: alu_res = '0;
    endcase
  end

  // low two bits dropped, all accesses are whole words
  assign mem_addr  = {alu_res[`MIPS_XLEN-1:2], 2'b00};
  assign writedata = ex.rt_data;  // sw stores rt

  always_ff @(posedge clk) begin
    if (reset) load_q <= '0;
    else if ((state == MEM) && ex.ctrl.mem_read && !waitrequest) load_q <= readdata;
  end

  // beq/bne compare the register operands directly
  assign take_branch = ex.ctrl.branch &&
                       (ex.ctrl.branch_ne ? (ex.rs_data != ex.rt_data)
                                          : (ex.rs_data == ex.rt_data));

  assign wr_addr = ex.dest;
  assign wr_data = ex.ctrl.mem_read ? load_q : alu_res;
  assign reg_we  = (state == EXEC) && ex.ctrl.reg_write;  // one-cycle write pulse

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module register_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  we,
  input  logic [4:0]            rs_addr,
  input  logic [4:0]            rt_addr,
  input  logic [4:0]            wr_addr,
  input  logic [`MIPS_XLEN-1:0] wr_data,
  output logic [`MIPS_XLEN-1:0] rs_data,
  output logic [`MIPS_XLEN-1:0] rt_data,
  output logic [`MIPS_XLEN-1:0] register_v0
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NREGS; i++) regs[i] <= '0;  // all registers start at zero
    end else if (we && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;  // r0 writes dropped
    end
  end

  // combinational reads with r0 held at zero by the write guard
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  assign register_v0 = regs[2];  // $v0 is the result register seen outside

  // register 0 reads zero on both ports
  a_r0_zero: assert property (@(posedge clk) disable iff (reset)
    ((rs_addr != 5'd0) || (rs_data == '0)) && ((rt_addr != 5'd0) || (rt_data == '0)));

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module instr_decoder (
  input  logic                      clk,
  input  logic                      reset,
  input  mips_ctrl_pkg::cpu_state_t state,
  input  logic [`MIPS_XLEN-1:0]     readdata,
  input  logic                      waitrequest,
  output logic [4:0]                rs_addr,
  output logic [4:0]                rt_addr,
  decode_if.decode                  dec,
  input  logic [`MIPS_XLEN-1:0]     rs_data,
  input  logic [`MIPS_XLEN-1:0]     rt_data
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  instr_u ir;  // instruction register
  ctrl_t  ctrl;

  // loaded when the fetch completes and cleared to a no-op on reset
  always_ff @(posedge clk) begin
    if (reset) ir <= '0;
    else if ((state == FETCH) && !waitrequest) ir <= instr_u'(readdata);
  end

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    case (ir.r.opcode)
      OP_SPECIAL: begin
        ctrl.reg_write  = 1'b1;
        ctrl.dest_is_rd = 1'b1;
        case (ir.r.funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jumpreg   = 1'b1;
          end
          default: ctrl.reg_write = 1'b0;  // unknown funct does nothing
        endcase
      end
      OP_ADDIU: {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
      OP_SLTI: begin
        {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
        ctrl.alu_op = ALU_SLT;
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        {ctrl.alu_src_imm, ctrl.reg_write, ctrl.imm_zero_ext} = 3'b111;
        ctrl.alu_op = (ir.i.opcode == OP_ANDI) ? ALU_AND :
                      (ir.i.opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
      end
      OP_LUI: begin
        {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
        ctrl.alu_op = ALU_LUI;
      end
      OP_BEQ: ctrl.branch = 1'b1;
      OP_BNE: {ctrl.branch, ctrl.branch_ne} = 2'b11;
      OP_LW:  {ctrl.alu_src_imm, ctrl.reg_write, ctrl.mem_read} = 3'b111;
      OP_SW:  {ctrl.alu_src_imm, ctrl.mem_write} = 2'b11;  // address = rs + imm
      OP_J:   ctrl.jump = 1'b1;
      default: ;  // unknown opcodes leave every control low
    endcase
  end

  assign rs_addr = ir.r.rs;
  assign rt_addr = ir.r.rt;

  assign dec.ctrl    = ctrl;
  assign dec.rs_data = rs_data;
  assign dec.rt_data = rt_data;
  assign dec.imm     = ctrl.imm_zero_ext ? {16'b0, ir.i.imm}
                                         : {{16{ir.i.imm[15]}}, ir.i.imm};
  assign dec.jtarget = ir.j.target;
  assign dec.dest    = ctrl.dest_is_rd ? ir.r.rd : ir.i.rt;

endmodule

`default_nettype wire

/* rtl/cpu_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

module cpu_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      waitrequest,
  input  logic                      mem_read,   // lw in flight
  input  logic                      mem_write,  // sw in flight
  input  logic [`MIPS_XLEN-1:0]     pc,
  input  logic [`MIPS_XLEN-1:0]     mem_addr,
  output mips_ctrl_pkg::cpu_state_t state,
  output logic                      active,
  output logic                      read,
  output logic                      write,
  output logic [`MIPS_XLEN-1:0]     address,
  input  logic                      halt_next   // next pc is the halt address
);
  import mips_ctrl_pkg::*;

  logic mem_op;
  assign mem_op = mem_read | mem_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= FETCH;
      active <= 1'b1;
    end else begin
      case (state)
        FETCH:  if (!waitrequest) state <= LATCH;   // word arrives this cycle
        LATCH:  state <= MEM;
        MEM:    if (!mem_op || !waitrequest) state <= EXEC;
        EXEC: begin
          if (halt_next) begin
            state  <= HALTED;
            active <= 1'b0;
          end else begin
            state <= FETCH;
          end
        end
        default: state <= HALTED;  // halted stays put until reset
      endcase
    end
  end

  // bus strobes follow the state directly, held while waitrequest is high
  assign read    = (state == FETCH) || ((state == MEM) && mem_read);
  assign write   = (state == MEM) && mem_write;
  assign address = (state == MEM) ? mem_addr : pc;  // data address only in MEM

  a_no_rd_wr: assert property (@(posedge clk) disable iff (reset)
    !(read && write));

  // a stalled request keeps address and strobes until accepted
  a_hold_req: assert property (@(posedge clk) disable iff (reset)
    ((read || write) && waitrequest) |=>
      ($stable(address) && $stable(read) && $stable(write)));

endmodule

`default_nettype wire

/* rtl/decode_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_core_config.svh"

// decoded instruction handed from decode to execute and pc logic
interface decode_if;
  import mips_ctrl_pkg::*;

  ctrl_t                ctrl;
  logic [`MIPS_XLEN-1:0] rs_data;
  logic [`MIPS_XLEN-1:0] rt_data;
  logic [`MIPS_XLEN-1:0] imm;      // already sign or zero extended
  logic [25:0]           jtarget;
  logic [4:0]            dest;     // rd or rt, chosen in decode

  modport decode (output ctrl, rs_data, rt_data, imm, jtarget, dest);
  modport exec   (input  ctrl, rs_data, rt_data, imm, jtarget, dest);

endinterface

`default_nettype wire

/* rtl/mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

  // multi-cycle sequence, one instruction in flight
  typedef enum logic [2:0] {
    FETCH  = 3'b000,  // instruction read on the bus
    LATCH  = 3'b001,  // ir holds the word, decode settles
    MEM    = 3'b010,  // data access for lw/sw, one idle cycle otherwise
    EXEC   = 3'b011,  // register write and pc update at the end
    HALTED = 3'b100
  } cpu_state_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,  // signed compare
    ALU_LUI = 3'd6   // immediate into the upper half
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    imm_zero_ext;  // andi/ori/xori
    logic    alu_src_imm;   // operand b from imm instead of rt
    logic    reg_write;
    logic    dest_is_rd;    // r-type writes rd, i-type writes rt
    logic    mem_read;
    logic    mem_write;
    logic    branch_ne;     // bne when set, beq otherwise
    logic    branch;
    logic    jump;
    logic    jumpreg;
  } ctrl_t;

endpackage

`default_nettype wire

/* rtl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  // primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,  // r-type, see funct
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // function codes under SPECIAL
  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } funct_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;   // unused, no shifts in this core
    funct_t     funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target;  // word index inside the current 256MB region
  } j_fmt_t;

  // one instruction word seen through all three formats
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_u;

endpackage

`default_nettype wire

/* include/mips_core_config.svh */
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// datapath and bus width, address and data share it
`define MIPS_XLEN 32

// architectural register count, r0 hardwired to zero
`define MIPS_NREGS 32

// boot address after reset, kseg1 boot rom
`define MIPS_RESET_PC 32'hBFC00000

// a jump to this address ends execution
`define MIPS_HALT_PC 32'h00000000

`endif
